/* files.f */
+incdir+include
hdl/sonar_pkg.sv
hdl/sonar_clock_gen.sv
hdl/pdm_decimator.sv
hdl/sample_window.sv
hdl/sonar_channel.sv
hdl/wb_sonar_regs.sv
hdl/sonar_top.sv
verification/tb_sonar_top.sv

/* hdl/pdm_decimator.sv */
`timescale 1ns/100ps
`default_nettype none

module pdm_decimator
    import sonar_pkg::*;
(
    input  wire logic       wb_clk_i,
    input  wire logic       wb_rst_i,
    input  wire clk_en_t    clk_en_i,
    input  wire logic       pdm_i,
    output logic [BUS_W-1:0] sample_o,
    output logic            sample_stb_o
);

    logic [BUS_W-1:0] ones_cnt;
    logic [BUS_W-1:0] ones_nxt;

    // Count includes the current bit, also on the ce_pcm tick
    assign ones_nxt = ones_cnt + BUS_W'(pdm_i);

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            ones_cnt     <= '0;
            sample_o     <= '0;
            sample_stb_o <= 1'b0;
        end else begin
            sample_stb_o <= 1'b0;
            if (clk_en_i.ce_pcm) begin  // Always coincides with ce_pdm
                sample_o     <= ones_nxt;
                sample_stb_o <= 1'b1;
                ones_cnt     <= '0;
            end else if (clk_en_i.ce_pdm) begin
                ones_cnt <= ones_nxt;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/sample_window.sv */
`timescale 1ns/100ps
`default_nettype none

module sample_window
    import sonar_pkg::*;
#(
    parameter int WIN_LOG2 = 2
) (
    input  wire logic             wb_clk_i,
    input  wire logic             wb_rst_i,
    input  wire logic [BUS_W-1:0] sample_i,
    input  wire logic             sample_stb_i,
    output logic [BUS_W-1:0]      level_o,
    output logic                  level_stb_o
);

    localparam int WIN_LEN = 1 << WIN_LOG2;
    localparam int SUM_W   = BUS_W + WIN_LOG2;

    logic [BUS_W-1:0] win [WIN_LEN];
    logic [SUM_W-1:0] sum_q;
    logic [SUM_W-1:0] sum_nxt;

    // Running sum, oldest sample leaves as the new one enters
    assign sum_nxt = sum_q + SUM_W'(sample_i) - SUM_W'(win[WIN_LEN-1]);

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            for (int i = 0; i < WIN_LEN; i++)
                win[i] <= '0;
            sum_q       <= '0;
            level_o     <= '0;
            level_stb_o <= 1'b0;
        end else begin
            level_stb_o <= sample_stb_i;
            if (sample_stb_i) begin
                win[0] <= sample_i;
                for (int i = 1; i < WIN_LEN; i++)
                    win[i] <= win[i-1];
                sum_q   <= sum_nxt;
                level_o <= BUS_W'(sum_nxt >> WIN_LOG2);  // Window average
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/sonar_channel.sv */
`timescale 1ns/100ps
`default_nettype none

module sonar_channel
    import sonar_pkg::*;
#(
    parameter int WIN_LOG2 = 2
) (
    input  wire logic      wb_clk_i,
    input  wire logic      wb_rst_i,
    input  wire chan_req_t req_i,
    output chan_rsp_t      rsp_o,
    input  wire clk_en_t   clk_en_i,
    input  wire logic      pdm_i,
    input  wire logic      mclear_i,
    output logic           echo_o
);

    logic [BUS_W-1:0] thresh_q;
    logic [BUS_W-1:0] sample;
    logic             sample_stb;
    logic [BUS_W-1:0] level;
    logic             level_stb;
    logic             thresh_wr;

    pdm_decimator u_dec (
        .wb_clk_i     (wb_clk_i),
        .wb_rst_i     (wb_rst_i),
        .clk_en_i     (clk_en_i),
        .pdm_i        (pdm_i),
        .sample_o     (sample),
        .sample_stb_o (sample_stb)
    );

    sample_window #(
        .WIN_LOG2 (WIN_LOG2)
    ) u_win (
        .wb_clk_i     (wb_clk_i),
        .wb_rst_i     (wb_rst_i),
        .sample_i     (sample),
        .sample_stb_i (sample_stb),
        .level_o      (level),
        .level_stb_o  (level_stb)
    );

    assign thresh_wr = req_i.sel && req_i.we && (req_i.reg_ofs == CH_THRESH);

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            thresh_q <= '1;  // No level can exceed all ones
            echo_o   <= 1'b0;
        end else begin
            if (thresh_wr)
                thresh_q <= req_i.wdat;
            // Clear wins over a compare in the same cycle
            if (mclear_i || thresh_wr)
                echo_o <= 1'b0;
            else if (level_stb && (level > thresh_q))
                echo_o <= 1'b1;
        end
    end

    // Sample and level are held registers inside the pipeline
    always_comb begin
        case (req_i.reg_ofs)
            CH_THRESH: rsp_o.rdat = thresh_q;
            CH_SAMPLE: rsp_o.rdat = sample;
            CH_LEVEL:  rsp_o.rdat = level;
            default:   rsp_o.rdat = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/sonar_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module sonar_clock_gen
    import sonar_pkg::*;
#(
    parameter int PDM_DIV = 4
) (
    input  wire logic        wb_clk_i,
    input  wire logic        wb_rst_i,
    input  wire logic [31:0] prescaler_i,
    input  wire logic        prescaler_wr_i,
    output clk_en_t          clk_en_o,
    output logic             mclk_o
);

    localparam int CNT_W = (PDM_DIV > 2) ? $clog2(PDM_DIV) : 1;
    localparam logic [CNT_W-1:0] DIV_LAST = CNT_W'(PDM_DIV - 1);

    logic [CNT_W-1:0] div_cnt;
    logic [CNT_W-1:0] div_nxt;
    logic             ce_pdm;
    logic [31:0]      pcm_cnt;

    assign div_nxt = (div_cnt == DIV_LAST) ? '0 : div_cnt + 1'b1;

    // Start at the last phase so the first rise comes with ce_pdm
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            div_cnt <= DIV_LAST;
            mclk_o  <= 1'b0;
            ce_pdm  <= 1'b0;
        end else begin
            div_cnt <= div_nxt;
            mclk_o  <= (div_nxt < CNT_W'(PDM_DIV / 2));  // High for first half
            ce_pdm  <= (div_nxt == '0);
        end
    end

    assign clk_en_o.ce_pdm = ce_pdm;
    assign clk_en_o.ce_pcm = ce_pdm && (pcm_cnt == prescaler_i);

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i || prescaler_wr_i)
            pcm_cnt <= '0;
        else if (clk_en_o.ce_pcm)
            pcm_cnt <= '0;
        else if (ce_pdm)
            pcm_cnt <= pcm_cnt + 1'b1;
    end

endmodule

`default_nettype wire

/* hdl/sonar_pkg.sv */
`default_nettype none

package sonar_pkg;

    localparam int BUS_W = 16;                 // Channel data, samples, levels
    localparam logic [3:0] SOC_REGION = 4'd3;  // Address bits 31:28

    // Global word offsets, channels start at word 2
    typedef enum logic [8:0] {
        GLB_STATUS    = 9'd0,
        GLB_PRESCALER = 9'd1
    } glb_reg_e;

    typedef enum logic [3:0] {
        CH_THRESH = 4'd0,  // Read/write
        CH_SAMPLE = 4'd1,  // Read only
        CH_LEVEL  = 4'd2   // Read only
    } chan_reg_e;

    typedef struct packed {
        logic             sel;      // One-cycle access strobe
        logic             we;
        chan_reg_e        reg_ofs;
        logic [BUS_W-1:0] wdat;
    } chan_req_t;

    typedef struct packed {
        logic [BUS_W-1:0] rdat;
    } chan_rsp_t;

    typedef struct packed {
        logic ce_pdm;
        logic ce_pcm;
    } clk_en_t;

endpackage

`default_nettype wire

/* hdl/sonar_top.sv */
`timescale 1ns/100ps
`default_nettype none

module sonar_top
    import sonar_pkg::*;
#(
    parameter int N_CHANNELS = 4,
    parameter int PDM_DIV    = 4,
    parameter int WIN_LOG2   = 2
) (
    input  wire logic                  wb_clk_i,
    input  wire logic                  wb_rst_i,
    input  wire logic                  wbs_cyc_i,
    input  wire logic                  wbs_stb_i,
    input  wire logic                  wbs_we_i,
    input  wire logic [3:0]            wbs_sel_i,
    input  wire logic [31:0]           wbs_adr_i,
    input  wire logic [31:0]           wbs_dat_i,
    output logic                       wbs_ack_o,
    output logic [31:0]                wbs_dat_o,
    input  wire logic [N_CHANNELS-1:0] pdm_i,
    input  wire logic                  mclear_i,
    output logic                       mclk_o,
    output logic                       irq_o
);

    clk_en_t                   clk_en;
    logic [31:0]               prescaler;
    logic                      prescaler_wr;
    chan_req_t [N_CHANNELS-1:0] chan_req;
    chan_rsp_t [N_CHANNELS-1:0] chan_rsp;
    logic [N_CHANNELS-1:0]     echo;

    sonar_clock_gen #(
        .PDM_DIV (PDM_DIV)
    ) u_clk (
        .wb_clk_i       (wb_clk_i),
        .wb_rst_i       (wb_rst_i),
        .prescaler_i    (prescaler),
        .prescaler_wr_i (prescaler_wr),
        .clk_en_o       (clk_en),
        .mclk_o         (mclk_o)
    );

    wb_sonar_regs #(
        .N_CHANNELS (N_CHANNELS)
    ) u_regs (
        .wb_clk_i       (wb_clk_i),
        .wb_rst_i       (wb_rst_i),
        .wbs_cyc_i      (wbs_cyc_i),
        .wbs_stb_i      (wbs_stb_i),
        .wbs_we_i       (wbs_we_i),
        .wbs_sel_i      (wbs_sel_i),
        .wbs_adr_i      (wbs_adr_i),
        .wbs_dat_i      (wbs_dat_i),
        .wbs_ack_o      (wbs_ack_o),
        .wbs_dat_o      (wbs_dat_o),
        .chan_req_o     (chan_req),
        .chan_rsp_i     (chan_rsp),
        .echo_i         (echo),
        .prescaler_o    (prescaler),
        .prescaler_wr_o (prescaler_wr),
        .irq_o          (irq_o)
    );

    for (genvar c = 0; c < N_CHANNELS; c++) begin : g_chan
        sonar_channel #(
            .WIN_LOG2 (WIN_LOG2)
        ) u_chan (
            .wb_clk_i (wb_clk_i),
            .wb_rst_i (wb_rst_i),
            .req_i    (chan_req[c]),
            .rsp_o    (chan_rsp[c]),
            .clk_en_i (clk_en),
            .pdm_i    (pdm_i[c]),
            .mclear_i (mclear_i),
            .echo_o   (echo[c])
        );
    end

endmodule

`default_nettype wire

/* hdl/wb_sonar_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module wb_sonar_regs
    import sonar_pkg::*;
#(
    parameter int N_CHANNELS = 4
) (
    input  wire logic                        wb_clk_i,
    input  wire logic                        wb_rst_i,
    input  wire logic                        wbs_cyc_i,
    input  wire logic                        wbs_stb_i,
    input  wire logic                        wbs_we_i,
    input  wire logic [3:0]                  wbs_sel_i,
    input  wire logic [31:0]                 wbs_adr_i,
    input  wire logic [31:0]                 wbs_dat_i,
    output logic                             wbs_ack_o,
    output logic [31:0]                      wbs_dat_o,
    output chan_req_t [N_CHANNELS-1:0]       chan_req_o,
    input  wire chan_rsp_t [N_CHANNELS-1:0]  chan_rsp_i,
    input  wire logic [N_CHANNELS-1:0]       echo_i,
    output logic [31:0]                      prescaler_o,
    output logic                             prescaler_wr_o,
    output logic                             irq_o
);

    logic                  acc;      // Request edge, ack low
    logic                  wr_en;
    glb_reg_e              word;
    logic [8:0]            chan_ofs;
    logic [4:0]            chan_num;
    logic                  is_chan;
    logic [BUS_W-1:0]      ch_rdat;
    logic [31:0]           rd_nxt;
    logic [N_CHANNELS-1:0] status_q;

    assign acc = wbs_cyc_i && wbs_stb_i && (wbs_adr_i[31:28] == SOC_REGION) && !wbs_ack_o;
    assign wr_en = wbs_we_i && wbs_sel_i[0];

    assign word     = glb_reg_e'(wbs_adr_i[10:2]);
    assign chan_ofs = wbs_adr_i[10:2] - 9'd2;
    assign chan_num = chan_ofs[8:4];
    assign is_chan  = (wbs_adr_i[10:2] >= 9'd2);

    assign prescaler_wr_o = acc && wr_en && (word == GLB_PRESCALER);
    assign irq_o = |status_q;

    // Fields are shared, only the addressed channel sees sel
    always_comb begin
        for (int c = 0; c < N_CHANNELS; c++) begin
            chan_req_o[c].sel     = acc && is_chan && (chan_num == c);
            chan_req_o[c].we      = wr_en;
            chan_req_o[c].reg_ofs = chan_reg_e'(chan_ofs[3:0]);
            chan_req_o[c].wdat    = wbs_dat_i[BUS_W-1:0];
        end
    end

    always_comb begin
        ch_rdat = '0;  // Channels past N_CHANNELS read 0
        for (int c = 0; c < N_CHANNELS; c++) begin
            if (is_chan && (chan_num == c))
                ch_rdat = chan_rsp_i[c].rdat;
        end
        case (word)
            GLB_STATUS:    rd_nxt = 32'(status_q);
            GLB_PRESCALER: rd_nxt = prescaler_o;
            default:       rd_nxt = {{(32-BUS_W){ch_rdat[BUS_W-1]}}, ch_rdat};
        endcase
    end

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            wbs_ack_o   <= 1'b0;
            status_q    <= '0;
            prescaler_o <= 32'd49;
        end else begin
            wbs_ack_o <= acc;
            status_q  <= echo_i;
            if (prescaler_wr_o)
                prescaler_o <= wbs_dat_i;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (acc)
            wbs_dat_o <= rd_nxt;  // Held while ack is high
    end

endmodule

`default_nettype wire

/* include/tb_sonar_ref.svh */
`ifndef TB_SONAR_REF_SVH
`define TB_SONAR_REF_SVH

// Sample for a PDM bit held constant over prescaler + 1 ticks
function automatic int unsigned ref_sample(input bit pdm_bit, input int unsigned prescaler);
    return pdm_bit ? ((prescaler + 1) & 32'h0000_ffff) : 0;
endfunction

// Average over a full window, list length is a power of two
function automatic int unsigned ref_level(input int unsigned samples[$]);
    longint unsigned sum;
    sum = 0;
    foreach (samples[i])
        sum += samples[i];
    if (samples.size() == 0)
        return 0;
    return int'(sum / samples.size());
endfunction

// One status bit per channel, set where level beats threshold
function automatic logic [31:0] ref_status(input int unsigned thresh[],
                                           input int unsigned level[]);
    logic [31:0] st;
    st = '0;
    foreach (level[i]) begin
        if ((i < 32) && (level[i] > thresh[i]))
            st[i] = 1'b1;
    end
    return st;
endfunction

`endif

/* verification/tb_sonar_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_sonar_top
    import sonar_pkg::*;
();

    localparam int N_CH       = 4;
    localparam int PDM_DIV    = 4;
    localparam int WIN_LOG2   = 2;
    localparam int CLK_PERIOD = 100;
    localparam int PRESC_RUN  = 3;                      // Prescaler for the datapath tests
    localparam logic [N_CH-1:0] PDM_PATTERN = 4'b1011;  // Constant PDM bit per channel

    // Run length: bus accesses, sample periods waited and the mclk window
    localparam int N_ACCESS    = 40;
    localparam int N_PERIODS   = 22;
    localparam int TEST_CYCLES = 2 + N_ACCESS * 3 + N_PERIODS * (PRESC_RUN + 1) * PDM_DIV + 44;
    localparam int TIMEOUT_CYC = 4 * TEST_CYCLES;

    logic              wb_clk_i = 1'b0;
    logic              wb_rst_i;
    logic              wbs_cyc_i;
    logic              wbs_stb_i;
    logic              wbs_we_i;
    logic [3:0]        wbs_sel_i;
    logic [31:0]       wbs_adr_i;
    logic [31:0]       wbs_dat_i;
    logic              wbs_ack_o;
    logic [31:0]       wbs_dat_o;
    logic [N_CH-1:0]   pdm_i;
    logic              mclear_i;
    logic              mclk_o;
    logic              irq_o;

    integer            seed = 84770;
    int                cycle_cnt = 0;
    int                n_errors = 0;
    string             chk_name[$];
    logic [31:0]       chk_got[$];
    logic [31:0]       chk_exp[$];
    time               chk_time[$];

    `include "tb_sonar_ref.svh"

    sonar_top #(
        .N_CHANNELS (N_CH),
        .PDM_DIV    (PDM_DIV),
        .WIN_LOG2   (WIN_LOG2)
    ) UUT (
        .wb_clk_i  (wb_clk_i),
        .wb_rst_i  (wb_rst_i),
        .wbs_cyc_i (wbs_cyc_i),
        .wbs_stb_i (wbs_stb_i),
        .wbs_we_i  (wbs_we_i),
        .wbs_sel_i (wbs_sel_i),
        .wbs_adr_i (wbs_adr_i),
        .wbs_dat_i (wbs_dat_i),
        .wbs_ack_o (wbs_ack_o),
        .wbs_dat_o (wbs_dat_o),
        .pdm_i     (pdm_i),
        .mclear_i  (mclear_i),
        .mclk_o    (mclk_o),
        .irq_o     (irq_o)
    );

    always #(CLK_PERIOD / 2) wb_clk_i = ~wb_clk_i;

    function automatic logic [31:0] glb_addr(input glb_reg_e w);
        return {SOC_REGION, 17'd0, w, 2'b00};
    endfunction

    // Channel words start at word 2, 16 words per channel
    function automatic logic [31:0] chan_addr(input int c, input chan_reg_e r);
        logic [8:0] word;
        word = 9'(2 + c * 16) + 9'(r);
        return {SOC_REGION, 17'd0, word, 2'b00};
    endfunction

    // Queue a result for the compare process
    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        chk_name.push_back(name);
        chk_got.push_back(got);
        chk_exp.push_back(exp);
        chk_time.push_back($time);
    endtask

    task automatic bus_access(input logic we, input logic [31:0] adr,
                              input logic [31:0] wdat, output logic [31:0] rdat);
        @(negedge wb_clk_i);
        wbs_cyc_i = 1'b1;
        wbs_stb_i = 1'b1;
        wbs_we_i  = we;
        wbs_sel_i = 4'hf;
        wbs_adr_i = adr;
        wbs_dat_i = wdat;
        @(negedge wb_clk_i);
        while (!wbs_ack_o)
            @(negedge wb_clk_i);
        rdat = wbs_dat_o;  // Valid while ack is high
        wbs_cyc_i = 1'b0;
        wbs_stb_i = 1'b0;
        wbs_we_i  = 1'b0;
        @(negedge wb_clk_i);
        check_val("wbs_ack_o", 32'(wbs_ack_o), 32'd0);  // Ack lasts one cycle
    endtask

    task automatic bus_write(input logic [31:0] adr, input logic [31:0] wdat);
        logic [31:0] unused;
        bus_access(1'b1, adr, wdat, unused);
    endtask

    task automatic bus_read(input logic [31:0] adr, output logic [31:0] rdat);
        bus_access(1'b0, adr, 32'd0, rdat);
    endtask

    // Counts mclk_o rising edges, one per PDM tick
    task automatic wait_pdm_ticks(input int n);
        int   seen;
        logic prev;
        seen = 0;
        prev = mclk_o;
        while (seen < n) begin
            @(negedge wb_clk_i);
            if (mclk_o && !prev)
                seen++;
            prev = mclk_o;
        end
    endtask

    always @(posedge wb_clk_i) begin : compare
        string       name;
        logic [31:0] got;
        logic [31:0] exp;
        time         t;
        while (chk_name.size() > 0) begin
            name = chk_name.pop_front();
            got  = chk_got.pop_front();
            exp  = chk_exp.pop_front();
            t    = chk_time.pop_front();
            assert (got === exp) else begin
                n_errors++;
                $display("MISMATCH at %0t ns: %s got 0x%08h expected 0x%08h", t, name, got, exp);
                $display("Simulation failed");
                $fatal(1, "Stopping at first error");
            end
        end
    end

    always @(posedge wb_clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYC) begin
            $display("ERROR: timeout, test sequence still running after %0d cycles", cycle_cnt);
            $display("Simulation failed");
            $fatal(1, "Timeout");
        end
    end

    initial begin : main_seq
        logic [31:0]  rd;
        logic [31:0]  st_exp;
        logic [31:0]  presc_rnd;
        logic [15:0]  t16;
        int unsigned  smp_exp;
        int unsigned  win_q[$];
        int unsigned  thresh_ref[];
        int unsigned  level_ref[];
        int           last_rise;
        int           last_fall;
        int           rises;
        logic         prev;
        thresh_ref = new[N_CH];
        level_ref  = new[N_CH];
        wb_rst_i  = 1'b1;
        wbs_cyc_i = 1'b0;
        wbs_stb_i = 1'b0;
        wbs_we_i  = 1'b0;
        wbs_sel_i = 4'h0;
        wbs_adr_i = 32'd0;
        wbs_dat_i = 32'd0;
        pdm_i     = PDM_PATTERN;
        mclear_i  = 1'b0;
        repeat (2) @(negedge wb_clk_i);
        wb_rst_i = 1'b0;

        // Reset values
        bus_read(glb_addr(GLB_STATUS), rd);
        check_val("status", rd, 32'd0);
        bus_read(glb_addr(GLB_PRESCALER), rd);
        check_val("prescaler", rd, 32'd49);
        for (int c = 0; c < N_CH; c++) begin
            bus_read(chan_addr(c, CH_THRESH), rd);
            check_val($sformatf("ch%0d thresh", c), rd, 32'hffff_ffff);
        end
        check_val("irq_o", 32'(irq_o), 32'd0);

        // Register access
        presc_rnd = $random(seed);
        bus_write(glb_addr(GLB_PRESCALER), presc_rnd);
        bus_read(glb_addr(GLB_PRESCALER), rd);
        check_val("prescaler", rd, presc_rnd);
        for (int c = 0; c < N_CH; c++) begin
            t16 = 16'($random(seed));
            bus_write(chan_addr(c, CH_THRESH), {16'd0, t16});
            bus_read(chan_addr(c, CH_THRESH), rd);
            check_val($sformatf("ch%0d thresh", c), rd, {{16{t16[15]}}, t16});
        end
        bus_read(chan_addr(N_CH, CH_THRESH), rd);
        check_val("unused channel thresh", rd, 32'd0);
        bus_read(chan_addr(N_CH + 3, CH_LEVEL), rd);
        check_val("unused channel level", rd, 32'd0);

        // Decimation and averaging, the first partial sample leaves the window
        bus_write(glb_addr(GLB_PRESCALER), PRESC_RUN);
        wait_pdm_ticks(6 * (PRESC_RUN + 1));
        for (int c = 0; c < N_CH; c++) begin
            smp_exp = ref_sample(PDM_PATTERN[c], PRESC_RUN);
            win_q.delete();
            repeat (1 << WIN_LOG2) win_q.push_back(smp_exp);
            level_ref[c] = ref_level(win_q);
            bus_read(chan_addr(c, CH_SAMPLE), rd);
            check_val($sformatf("ch%0d sample", c), rd, smp_exp);
            bus_read(chan_addr(c, CH_LEVEL), rd);
            check_val($sformatf("ch%0d level", c), rd, level_ref[c]);
        end

        // Echo detection
        for (int c = 0; c < N_CH; c++) begin
            thresh_ref[c] = $unsigned($random(seed)) % 9;
            bus_write(chan_addr(c, CH_THRESH), thresh_ref[c]);
        end
        wait_pdm_ticks(2 * (PRESC_RUN + 1));
        st_exp = ref_status(thresh_ref, level_ref);
        bus_read(glb_addr(GLB_STATUS), rd);
        check_val("status", rd, st_exp);
        check_val("irq_o", 32'(irq_o), 32'(st_exp != 0));

        // Clear, flags on channels 0 and 3 are forced on first
        thresh_ref[0] = 0;
        thresh_ref[3] = 0;
        bus_write(chan_addr(0, CH_THRESH), thresh_ref[0]);
        bus_write(chan_addr(3, CH_THRESH), thresh_ref[3]);
        wait_pdm_ticks(2 * (PRESC_RUN + 1));
        st_exp = ref_status(thresh_ref, level_ref);
        bus_read(glb_addr(GLB_STATUS), rd);
        check_val("status", rd, st_exp);

        // Channel 3 goes quiet, its flag stays until the clear
        @(negedge wb_clk_i);
        pdm_i[3] = 1'b0;
        win_q.delete();
        repeat (1 << WIN_LOG2) win_q.push_back(ref_sample(1'b0, PRESC_RUN));
        level_ref[3] = ref_level(win_q);
        wait_pdm_ticks(6 * (PRESC_RUN + 1));
        bus_read(glb_addr(GLB_STATUS), rd);
        check_val("status", rd, st_exp);

        // Flags come back only where the level still beats the threshold
        @(negedge wb_clk_i);
        mclear_i = 1'b1;
        @(negedge wb_clk_i);
        mclear_i = 1'b0;
        wait_pdm_ticks(2 * (PRESC_RUN + 1));
        st_exp = ref_status(thresh_ref, level_ref);
        bus_read(glb_addr(GLB_STATUS), rd);
        check_val("status", rd, st_exp);
        thresh_ref[0] = level_ref[0] + 16;
        bus_write(chan_addr(0, CH_THRESH), thresh_ref[0]);
        st_exp = ref_status(thresh_ref, level_ref);
        wait_pdm_ticks(2 * (PRESC_RUN + 1));
        bus_read(glb_addr(GLB_STATUS), rd);
        check_val("status", rd, st_exp);
        wait_pdm_ticks(2 * (PRESC_RUN + 1));
        bus_read(glb_addr(GLB_STATUS), rd);
        check_val("status bit 0", 32'(rd[0]), 32'd0);
        check_val("irq_o", 32'(irq_o), 32'(st_exp != 0));

        // Microphone clock period, rise to rise and fall to fall
        last_rise = -1;
        last_fall = -1;
        rises     = 0;
        prev      = mclk_o;
        for (int i = 0; i < 40; i++) begin
            @(negedge wb_clk_i);
            if (mclk_o && !prev) begin
                if (last_rise >= 0)
                    check_val("mclk_o rise period", i - last_rise, PDM_DIV);
                last_rise = i;
                rises++;
            end
            if (!mclk_o && prev) begin
                if (last_fall >= 0)
                    check_val("mclk_o fall period", i - last_fall, PDM_DIV);
                last_fall = i;
            end
            prev = mclk_o;
        end
        check_val("mclk_o rising edges", rises, 40 / PDM_DIV);

        @(posedge wb_clk_i);  // Compare process drains the queue here
        @(negedge wb_clk_i);
        if (n_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
